// File: logic/ahb_macros.svh
/* Edit the widths here. AHB_ADDR_BITS may be 32, 34 or 56 and AHB_DATA_BITS 32 or 64.
   The reset values give an idle word-sized SINGLE read at address zero */
`ifndef AHB_MACROS_SVH
`define AHB_MACROS_SVH

// Physical address width seen on HADDR
`define AHB_ADDR_BITS 32

// Width of HWDATA and HRDATA
`define AHB_DATA_BITS 32

// Counter width that holds a beat count of up to 16
`define AHB_BEAT_BITS 5

//////////////////////////////////////////////////
// Address-phase values held after reset
//////////////////////////////////////////////////
`define AHB_RESET_WRITE 1'b0
`define AHB_RESET_SIZE  3'd2
`define AHB_RESET_BURST 3'd0
`define AHB_RESET_TRANS 2'd0
`define AHB_RESET_ADDR  {`AHB_ADDR_BITS{1'b0}}

`endif

// File: logic/ahbPkg.sv
/* AHB-Lite types shared by the front end. HPROT and HMASTLOCK are not carried,
   and HRESP is assumed to be OKAY at all times */
`default_nettype none

`include "ahb_macros.svh"

package ahbPkg;

  // Transfer type, encoded as on HTRANS
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  // Burst type, encoded as on HBURST
  // Wrapping bursts are handled like the INCR burst of the same length
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburstT;

  // Log2 of the transfer size in bytes
  typedef logic [2:0] hsizeT;

  // One complete address phase
  typedef struct packed {
    logic                      write;
    hsizeT                     size;
    hburstT                    burst;
    htransT                    trans;
    logic [`AHB_ADDR_BITS-1:0] addr;
  } ahbReqT;

  // Which manager owns the bus
  typedef enum logic {
    IFU = 1'b0,
    LSU = 1'b1
  } managerIdT;

  typedef logic [`AHB_DATA_BITS-1:0] dataT;

  // Idle address phase used after reset and whenever the bus is held off
  localparam ahbReqT idleReq = '{
    write: `AHB_RESET_WRITE,
    size:  hsizeT'(`AHB_RESET_SIZE),
    burst: hburstT'(`AHB_RESET_BURST),
    trans: htransT'(`AHB_RESET_TRANS),
    addr:  `AHB_RESET_ADDR
  };

endpackage

`default_nettype wire

// File: logic/managerInputStage.sv
/* The manager must keep its address phase stable while its HREADY is low.
   The saved copy is only meaningful after a save strobe */
`timescale 1ns/1ps
`default_nettype none

module managerInputStage import ahbPkg::*; (
  input  logic   HCLK,
  input  logic   rstN,
  // Strobes from the arbiter
  input  logic   save,
  input  logic   restore,
  input  logic   disableMgr,
  // Address phase from the manager and toward the arbiter
  input  ahbReqT reqIn,
  output ahbReqT reqOut,
  // Ready from the subordinate and back to the manager
  input  logic   readyIn,
  output logic   readyOut,
  // Status back to the arbiter
  output logic   request,
  output logic   active
);

  // Copy of the address phase that lost arbitration
  ahbReqT savedReq;

  //////////////////////////////////////////////////
  // Capture and replay
  //////////////////////////////////////////////////

  // The copy is taken on the edge that carries the save strobe
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      savedReq <= idleReq;
    end else if (save) begin
      savedReq <= reqIn;
    end
  end

  // Live request passes straight through unless a replay is running
  assign reqOut = restore ? savedReq : reqIn;

  //////////////////////////////////////////////////
  // Status and ready gating
  //////////////////////////////////////////////////

  // Anything but IDLE counts as a request, BUSY included
  assign request = (reqOut.trans != IDLE);

  // A stalled manager sees HREADY low and so holds its address phase
  assign readyOut = readyIn & ~disableMgr;

  // Set when this stage's address phase is taken on the coming edge
  assign active = request & readyOut;

endmodule

`default_nettype wire

// File: logic/beatCounter.sv
/* Counts beats of the burst that is on the bus, up to 16. Undefined-length INCR
   loads zero and never flags a last beat, so its end is found by the arbiter */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_macros.svh"

module beatCounter import ahbPkg::*; (
  input  logic   HCLK,
  input  logic   rstN,
  // Burst and transfer type currently driven to the subordinate
  input  hburstT burst,
  input  htransT trans,
  // Subordinate ready; a beat is taken only on NONSEQ or SEQ
  input  logic   accept,
  output logic   lastBeat
);

  typedef logic [`AHB_BEAT_BITS-1:0] countT;

  // Beats left, counting the one now on the bus
  countT remain;
  // Beats of a burst that starts now
  countT burstLen;
  // Count that applies to the present beat
  countT curCount;
  logic  taken;

  // Length of a new burst from its HBURST code
  always_comb begin
    case (burst)
      SINGLE:         burstLen = countT'(1);
      WRAP4, INCR4:   burstLen = countT'(4);
      WRAP8, INCR8:   burstLen = countT'(8);
      WRAP16, INCR16: burstLen = countT'(16);
      default:        burstLen = countT'(0);
    endcase
  end

  // A NONSEQ starts fresh and any other beat continues the stored count
  assign curCount = (trans == NONSEQ) ? burstLen : remain;

  assign taken = accept && ((trans == NONSEQ) || (trans == SEQ));

  // True for a SINGLE and for the final beat of a fixed burst
  assign lastBeat = (curCount == countT'(1));

  //////////////////////////////////////////////////
  // Beat count register
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      remain <= '0;
    end else if (taken) begin
      // Zero stays zero for undefined-length bursts
      remain <= (curCount == '0) ? '0 : curCount - countT'(1);
    end
  end

endmodule

`default_nettype wire

// File: logic/busArbiter.sv
/* Two managers with fixed LSU priority. A fixed-length burst is never broken up;
   an INCR burst ends when its owner drives IDLE or a new NONSEQ */
`timescale 1ns/1ps
`default_nettype none

module busArbiter import ahbPkg::*; (
  input  logic      HCLK,
  input  logic      rstN,
  // Address phases and status from both input stages
  input  ahbReqT    ifuReq,
  input  ahbReqT    lsuReq,
  input  logic      ifuRequest,
  input  logic      lsuRequest,
  input  dataT      ifuWdata,
  input  dataT      lsuWdata,
  input  logic      subHREADY,
  input  logic      lastBeat,
  // Strobes to the IFU stage
  output logic      ifuSave,
  output logic      ifuRestore,
  output logic      ifuDisable,
  // Strobes to the LSU stage
  output logic      lsuSave,
  output logic      lsuRestore,
  output logic      lsuDisable,
  // Merged manager port
  output ahbReqT    sub,
  output dataT      subHWDATA,
  output managerIdT grant
);

  typedef enum logic [1:0] {ARB_IDLE, ARB_BURST, ARB_REPLAY} arbStateT;

  arbStateT  state, stateNext;
  managerIdT owner, otherId, grantNext, dataGrant;
  ahbReqT    ownerBus;
  logic      pending, pendingNext;
  logic      otherReq, otherSave, incrEnd, hold, accept;
  // A transfer sat on the bus through the last wait state
  logic      stalled;

  //////////////////////////////////////////////////
  // Ownership of the address phase
  //////////////////////////////////////////////////
  always_comb begin
    // Owner only changes on a ready cycle with no stalled transfer on the bus
    owner = grant;
    if ((state == ARB_IDLE) && subHREADY && !stalled) begin
      if (lsuRequest) begin
        owner = LSU;
      end else if (ifuRequest) begin
        owner = IFU;
      end
    end
  end

  assign otherId  = (owner == LSU) ? IFU : LSU;
  assign ownerBus = (owner == LSU) ? lsuReq : ifuReq;
  assign otherReq = (owner == LSU) ? ifuRequest : lsuRequest;

  // Owner dropped out of its burst with IDLE or opened a new one with NONSEQ
  assign incrEnd = (state == ARB_BURST) &&
                   ((ownerBus.trans == IDLE) || (ownerBus.trans == NONSEQ));
  // A waiting manager goes first, so the owner's next NONSEQ is held back
  assign hold    = incrEnd && pending;

  assign sub    = hold ? idleReq : ownerBus;
  assign accept = subHREADY && ((sub.trans == NONSEQ) || (sub.trans == SEQ));

  // The loser is copied once, on a ready edge, and then waits
  assign otherSave = subHREADY && otherReq && !pending;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb begin
    stateNext   = state;
    grantNext   = grant;
    pendingNext = pending | otherSave;
    // While idle the grant just follows the priority pick
    if (state == ARB_IDLE) begin
      grantNext = owner;
    end
    if (accept) begin
      grantNext = owner;
      if (!lastBeat) begin
        stateNext = ARB_BURST;
      end else if (pending || otherSave) begin
        stateNext   = ARB_REPLAY;
        grantNext   = otherId;
        pendingNext = 1'b0;
      end else begin
        stateNext = ARB_IDLE;
      end
    end else if (incrEnd && subHREADY) begin
      if (pending) begin
        stateNext   = ARB_REPLAY;
        grantNext   = otherId;
        pendingNext = 1'b0;
      end else begin
        stateNext = ARB_IDLE;
      end
    end
  end

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      state     <= ARB_IDLE;
      grant     <= LSU;
      pending   <= 1'b0;
      dataGrant <= LSU;
      stalled   <= 1'b0;
    end else begin
      state     <= stateNext;
      grant     <= grantNext;
      pending   <= pendingNext;
      // A transfer shown in a wait state stays on the bus until it is taken
      stalled   <= !subHREADY && ((sub.trans == NONSEQ) || (sub.trans == SEQ));
      // Data phase belongs to whoever owned the accepted address phase
      if (accept) begin
        dataGrant <= owner;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage strobes and write data
  //////////////////////////////////////////////////

  // Restore is taken from registers only, which keeps request out of the loop
  assign ifuRestore = (state == ARB_REPLAY) && (grant == IFU);
  assign lsuRestore = (state == ARB_REPLAY) && (grant == LSU);

  assign ifuSave = (owner == LSU) && otherSave;
  assign lsuSave = (owner == IFU) && otherSave;

  // The loser stalls while it asks, and the owner stalls while held back
  assign ifuDisable = (owner == IFU) ? hold : otherReq;
  assign lsuDisable = (owner == LSU) ? hold : otherReq;

  assign subHWDATA = (dataGrant == LSU) ? lsuWdata : ifuWdata;

endmodule

`default_nettype wire

// File: logic/busMultiManager.sv
/* Merges the IFU and LSU onto one AHB-Lite manager port for a single subordinate.
   HRESP is not routed, so error responses are not supported */
`timescale 1ns/1ps
`default_nettype none

module busMultiManager import ahbPkg::*; (
  input  logic   HCLK,
  input  logic   rstN,
  // Instruction fetch manager
  input  ahbReqT ifuReq,
  input  dataT   ifuHWDATA,
  output logic   ifuHREADY,
  // Load/store manager
  input  ahbReqT lsuReq,
  input  dataT   lsuHWDATA,
  output logic   lsuHREADY,
  // Subordinate side
  output ahbReqT sub,
  output dataT   subHWDATA,
  input  logic   subHREADY,
  input  dataT   subHRDATA,
  output dataT   HRDATA
);

  // Address phases after the replay muxes
  ahbReqT    ifuStageReq;
  ahbReqT    lsuStageReq;

  // Arbiter strobes
  logic      ifuSave, ifuRestore, ifuDisable;
  logic      lsuSave, lsuRestore, lsuDisable;

  // Stage status
  logic      ifuRequest, ifuActive;
  logic      lsuRequest, lsuActive;

  logic      lastBeat;

  // Bus owner, kept at the top for debug and protocol checks
  managerIdT grant;

  //////////////////////////////////////////////////
  // Manager input stages
  //////////////////////////////////////////////////
  managerInputStage ifuStage (
    .HCLK       (HCLK),
    .rstN       (rstN),
    .save       (ifuSave),
    .restore    (ifuRestore),
    .disableMgr (ifuDisable),
    .reqIn      (ifuReq),
    .reqOut     (ifuStageReq),
    .readyIn    (subHREADY),
    .readyOut   (ifuHREADY),
    .request    (ifuRequest),
    .active     (ifuActive)
  );

  managerInputStage lsuStage (
    .HCLK       (HCLK),
    .rstN       (rstN),
    .save       (lsuSave),
    .restore    (lsuRestore),
    .disableMgr (lsuDisable),
    .reqIn      (lsuReq),
    .reqOut     (lsuStageReq),
    .readyIn    (subHREADY),
    .readyOut   (lsuHREADY),
    .request    (lsuRequest),
    .active     (lsuActive)
  );

  //////////////////////////////////////////////////
  // Burst tracking and arbitration
  //////////////////////////////////////////////////

  // Watches the merged port so it follows whichever manager owns it
  beatCounter beatCount (
    .HCLK     (HCLK),
    .rstN     (rstN),
    .burst    (sub.burst),
    .trans    (sub.trans),
    .accept   (subHREADY),
    .lastBeat (lastBeat)
  );

  busArbiter arbiter (
    .HCLK       (HCLK),
    .rstN       (rstN),
    .ifuReq     (ifuStageReq),
    .lsuReq     (lsuStageReq),
    .ifuRequest (ifuRequest),
    .lsuRequest (lsuRequest),
    .ifuWdata   (ifuHWDATA),
    .lsuWdata   (lsuHWDATA),
    .subHREADY  (subHREADY),
    .lastBeat   (lastBeat),
    .ifuSave    (ifuSave),
    .ifuRestore (ifuRestore),
    .ifuDisable (ifuDisable),
    .lsuSave    (lsuSave),
    .lsuRestore (lsuRestore),
    .lsuDisable (lsuDisable),
    .sub        (sub),
    .subHWDATA  (subHWDATA),
    .grant      (grant)
  );

  // Each manager picks its own read data by its HREADY
  assign HRDATA = subHRDATA;

endmodule

`default_nettype wire

// File: testbench/busMultiManager_chk.sv
/* Protocol checks on the merged port, bound into the top level.
   Only wait-state behavior and arbitration are covered */
`timescale 1ns/1ps
`default_nettype none

module busMultiManager_chk import ahbPkg::*; (
  input logic      HCLK,
  input logic      rstN,
  input ahbReqT    sub,
  input logic      subHREADY,
  input logic      ifuHREADY,
  input logic      lsuHREADY,
  input ahbReqT    ifuStageReq,
  input ahbReqT    lsuStageReq,
  input logic      ifuActive,
  input logic      lsuActive,
  input managerIdT grant
);

  // A wait state reaches both managers
  waitStallsBoth: assert property (@(posedge HCLK) disable iff (!rstN)
    !subHREADY |-> (!ifuHREADY && !lsuHREADY))
    else $error("HREADY high at a manager during a wait state");

  // A transfer shown during a wait state is still there in the next cycle
  subStableInWait: assert property (@(posedge HCLK) disable iff (!rstN)
    (!subHREADY && ((sub.trans == NONSEQ) || (sub.trans == SEQ)))
    |=> $stable(sub))
    else $error("sub changed while the subordinate was waiting");

  // A manager sees its transfer taken only when that transfer is on the bus
  ifuTakenOnBus: assert property (@(posedge HCLK) disable iff (!rstN)
    ifuActive |-> (sub == ifuStageReq))
    else $error("IFU transfer taken while another phase was on the bus");

  lsuTakenOnBus: assert property (@(posedge HCLK) disable iff (!rstN)
    lsuActive |-> (sub == lsuStageReq))
    else $error("LSU transfer taken while another phase was on the bus");

  // Burst beats after the first come from the granted manager
  seqFromGrant: assert property (@(posedge HCLK) disable iff (!rstN)
    (subHREADY && (sub.trans == SEQ)) |-> ((grant == LSU) ? lsuActive : ifuActive))
    else $error("SEQ beat taken from a manager that does not hold the grant");

  // SEQ only inside a burst
  seqInBurst: assert property (@(posedge HCLK) disable iff (!rstN)
    (sub.trans == SEQ) |-> (sub.burst != SINGLE))
    else $error("SEQ beat on a SINGLE transfer");

endmodule

`default_nettype wire

// File: testbench/busMultiManagerTb.sv
/* Random fixed-length bursts from both managers into a word memory with random wait states.
   IFU addresses live in the lower 512 bytes and LSU addresses in the upper 512 bytes */
`timescale 1ns/1ps
`default_nettype none

module busMultiManagerTb import ahbPkg::*; ();

  localparam int BurstsPerMgr = 12;
  localparam int ResetCycles  = 16;
  // Upper bound on beats, every burst an INCR16
  localparam int MaxBeats     = 2 * BurstsPerMgr * 16;
  localparam int LimitCycles  = MaxBeats * 40 + ResetCycles + 20;

  logic   HCLK;
  logic   rstN;
  ahbReqT mReq [2];
  dataT   mWdata [2];
  logic   ifuHREADY;
  logic   lsuHREADY;
  ahbReqT sub;
  dataT   subHWDATA;
  dataT   subHRDATA;
  dataT   HRDATA;
  logic   subHREADY;

  // Subordinate memory, one word per entry over a 1 KB window
  dataT   mem [256];

  // Transfers as issued by each manager, oldest first
  ahbReqT ifuQ[$];
  ahbReqT lsuQ[$];
  dataT   ifuDataQ[$];
  dataT   lsuDataQ[$];

  // Accepted address phases in bus order, with the data that belongs to them
  ahbReqT logReq [MaxBeats];
  dataT   logData [MaxBeats];
  int     logLen;

  // Data phase now open on the subordinate side
  logic   dpValid;
  int     dpIdx;

  int     burstLeft;
  int     burstOwner;
  int     beatsIssued;
  int     checks;
  int     errors;
  logic [31:0] rngState;
  logic [31:0] waitRng;

  busMultiManager UUT (
    .HCLK      (HCLK),
    .rstN      (rstN),
    .ifuReq    (mReq[0]),
    .ifuHWDATA (mWdata[0]),
    .ifuHREADY (ifuHREADY),
    .lsuReq    (mReq[1]),
    .lsuHWDATA (mWdata[1]),
    .lsuHREADY (lsuHREADY),
    .sub       (sub),
    .subHWDATA (subHWDATA),
    .subHREADY (subHREADY),
    .subHRDATA (subHRDATA),
    .HRDATA    (HRDATA)
  );

  bind busMultiManager busMultiManager_chk chk (.*);

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // Initial memory word, a hash of the full byte address
  function automatic dataT fillWord(input int idx);
    logic [31:0] a;
    a = 32'(idx) << 2;
    return dataT'((a * 32'h9E37_79B1) ^ 32'hC0DE_0000 ^ a);
  endfunction

  // Beats in a burst by the AHB rules, wrapping counted like INCR
  function automatic int burstBeats(input hburstT b);
    case (b)
      WRAP4, INCR4:   return 4;
      WRAP8, INCR8:   return 8;
      WRAP16, INCR16: return 16;
      default:        return 1;
    endcase
  endfunction

  // Expected read data for log entry k from all earlier writes to the same word
  function automatic dataT refRead(input int k);
    int   idx;
    int   j;
    dataT v;
    idx = int'(logReq[k].addr[9:2]);
    v = fillWord(idx);
    for (j = 0; j < k; j++) begin
      if (logReq[j].write && (int'(logReq[j].addr[9:2]) == idx)) begin
        v = logData[j];
      end
    end
    return v;
  endfunction

  task automatic checkReq(input string name, input ahbReqT got, input ahbReqT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkData(input string name, input dataT got, input dataT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Manager driver
  //////////////////////////////////////////////////
  task automatic issueBursts(input int id);
    ahbReqT      r;
    dataT        d;
    logic [31:0] rnd;
    logic        rdy;
    int          beats;
    int          startIdx;
    int          gap;
    int          n;
    int          b;
    for (n = 0; n < BurstsPerMgr; n++) begin
      rnd = nextRand();
      case (rnd[1:0])
        2'd0:    r.burst = SINGLE;
        2'd1:    r.burst = INCR4;
        2'd2:    r.burst = INCR8;
        default: r.burst = INCR16;
      endcase
      beats    = burstBeats(r.burst);
      r.write  = rnd[2];
      r.size   = hsizeT'(2);
      r.addr   = '0;
      // Start low enough that an INCR16 stays inside the manager's half
      startIdx = int'(rnd[14:8]) % 112;
      for (b = 0; b < beats; b++) begin
        r.trans     = (b == 0) ? NONSEQ : SEQ;
        r.addr[9]   = id[0];
        r.addr[8:2] = 7'(startIdx + b);
        d = dataT'(nextRand());
        mReq[id] <= r;
        if (id == 0) begin
          ifuQ.push_back(r);
          ifuDataQ.push_back(d);
        end else begin
          lsuQ.push_back(r);
          lsuDataQ.push_back(d);
        end
        beatsIssued++;
        // Hold the address phase until this manager's HREADY takes it
        do begin
          @(posedge HCLK);
          rdy = (id == 0) ? ifuHREADY : lsuHREADY;
        end while (!rdy);
        mWdata[id] <= d;
      end
      gap = int'(rnd[17:16]);
      if (gap > 0) begin
        mReq[id] <= idleReq;
        repeat (gap) @(posedge HCLK);
      end
    end
    mReq[id] <= idleReq;
  endtask

  //////////////////////////////////////////////////
  // Clock, wait states and subordinate read data
  //////////////////////////////////////////////////
  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  // Roughly one cycle in four is a wait state
  always @(posedge HCLK) begin
    if (rstN) begin
      waitRng = xorshift(waitRng);
      subHREADY <= (waitRng[1:0] != 2'b00);
    end
  end

  assign subHRDATA = (dpValid && !logReq[dpIdx].write) ? mem[logReq[dpIdx].addr[9:2]] : '0;

  //////////////////////////////////////////////////
  // Compare process on the subordinate side
  //////////////////////////////////////////////////
  always @(posedge HCLK) begin : compare
    int     id;
    ahbReqT exp;
    dataT   expData;
    if (rstN) begin
      // Finish the open data phase before taking a new address phase
      if (dpValid && subHREADY) begin
        if (logReq[dpIdx].write) begin
          checkData("subHWDATA", subHWDATA, logData[dpIdx]);
          mem[logReq[dpIdx].addr[9:2]] = subHWDATA;
        end else begin
          checkData("HRDATA", HRDATA, refRead(dpIdx));
        end
        dpValid = 1'b0;
      end
      if (subHREADY && ((sub.trans == NONSEQ) || (sub.trans == SEQ))) begin
        id = int'(sub.addr[9]);
        if (((id == 0) && (ifuQ.size() == 0)) || ((id == 1) && (lsuQ.size() == 0))) begin
          errors++;
          $display("t=%0t a transfer reached the subordinate that no manager issued", $time);
        end else begin
          exp     = (id == 0) ? ifuQ.pop_front() : lsuQ.pop_front();
          expData = (id == 0) ? ifuDataQ.pop_front() : lsuDataQ.pop_front();
          checkReq("sub", sub, exp);
          // A fixed burst must run to its end without the other manager
          if (burstLeft > 0) begin
            if ((id != burstOwner) || (sub.trans != SEQ)) begin
              errors++;
              $display("t=%0t a fixed burst was broken by another transfer", $time);
            end
            burstLeft--;
          end else begin
            burstOwner = id;
            burstLeft  = burstBeats(sub.burst) - 1;
          end
          logReq[logLen]  = sub;
          logData[logLen] = expData;
          dpIdx   = logLen;
          logLen++;
          dpValid = 1'b1;
        end
      end
    end
  end

  // Wait states must stall both managers
  always @(negedge HCLK) begin
    if (rstN && !subHREADY && (ifuHREADY || lsuHREADY)) begin
      errors++;
      $display("t=%0t a manager saw HREADY high during a wait state", $time);
    end
  end

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////
  initial begin
    repeat (LimitCycles) @(posedge HCLK);
    $display("the watchdog expired before all bursts completed");
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    rngState    = 32'd30;
    waitRng     = 32'd30;
    rstN        = 1'b0;
    subHREADY   = 1'b1;
    mReq[0]     = idleReq;
    mReq[1]     = idleReq;
    mWdata[0]   = '0;
    mWdata[1]   = '0;
    logLen      = 0;
    dpValid     = 1'b0;
    dpIdx       = 0;
    burstLeft   = 0;
    burstOwner  = 0;
    beatsIssued = 0;
    checks      = 0;
    errors      = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fillWord(i);
    end
    repeat (ResetCycles) @(posedge HCLK);
    rstN <= 1'b1;

    // Idle bus after reset, HREADY passed straight through
    repeat (8) begin
      @(negedge HCLK);
      checks++;
      if ((sub.trans != IDLE) || (ifuHREADY !== subHREADY) || (lsuHREADY !== subHREADY)) begin
        errors++;
        $display("t=%0t the bus was not idle with HREADY passed through after reset", $time);
      end
    end

    @(posedge HCLK);
    fork
      issueBursts(0);
      issueBursts(1);
    join
    // The last data phase is seen between edges, clear of the compare process
    @(negedge HCLK);
    while (dpValid) @(negedge HCLK);
    repeat (2) @(posedge HCLK);

    if ((ifuQ.size() != 0) || (lsuQ.size() != 0) || (logLen != beatsIssued)) begin
      errors++;
      $display("issued %0d beats but the subordinate accepted %0d", beatsIssued, logLen);
    end
    $display("beats %0d checks %0d errors %0d", logLen, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/ahbPkg.sv
logic/managerInputStage.sv
logic/beatCounter.sv
logic/busArbiter.sv
logic/busMultiManager.sv
testbench/busMultiManager_chk.sv
testbench/busMultiManagerTb.sv

// File: Bender.yml
package:
  name: busMultiManager

sources:
  - include_dirs:
      - logic
    files:
      - logic/ahbPkg.sv
      - logic/managerInputStage.sv
      - logic/beatCounter.sv
      - logic/busArbiter.sv
      - logic/busMultiManager.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/busMultiManager_chk.sv
      - testbench/busMultiManagerTb.sv
